/* design/cache_defines.svh */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// word and line geometry
`define WORD_BYTES 4
`define LINE_WORDS 4

// lines held by the bank
`define NUM_LINES 16

// line address, low bits index the bank
`define LINE_ADDR_BITS 10

// tag carried from request to response
`define CORE_TAG_BITS 4

// queue depths
`define CREQ_DEPTH 4
`define DREQ_DEPTH 4

`endif

/* design/cache_pkg.sv */
`default_nettype none

`include "cache_defines.svh"

package cache_pkg;

    typedef logic [`WORD_BYTES*8-1:0] word_t;
    typedef logic [`LINE_WORDS*`WORD_BYTES*8-1:0] line_t;

    typedef logic [`WORD_BYTES-1:0] word_byteen_t;
    typedef logic [`LINE_WORDS*`WORD_BYTES-1:0] line_byteen_t;

    typedef logic [$clog2(`LINE_WORDS)-1:0] word_sel_t;

    // line address splits into tag (high) and index (low)
    typedef logic [`LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [$clog2(`NUM_LINES)-1:0] line_index_t;
    typedef logic [`LINE_ADDR_BITS-$clog2(`NUM_LINES)-1:0] line_tag_t;

    typedef logic [`CORE_TAG_BITS-1:0] core_tag_t;

    typedef enum logic [1:0] {
        IDLE,
        RESPOND,
        FILL_REQ,
        FILL_WAIT
    } bank_state_e;

endpackage

`default_nettype wire

/* design/req_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module req_queue #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH      = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  logic [DATA_WIDTH-1:0] data_in,
    input  logic                  pop,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  full,
    output logic                  empty
);

    localparam int PTR_BITS   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_BITS = $clog2(DEPTH + 1);

    localparam logic [PTR_BITS-1:0]   LAST_PTR   = PTR_BITS'(DEPTH - 1);
    localparam logic [COUNT_BITS-1:0] FULL_COUNT = COUNT_BITS'(DEPTH);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_BITS-1:0]   rd_ptr;
    logic [PTR_BITS-1:0]   wr_ptr;
    logic [COUNT_BITS-1:0] count;
    logic                  do_push;
    logic                  do_pop;

    // overflow and underflow attempts are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full     = (count == FULL_COUNT);
    assign empty    = (count == '0);
    assign data_out = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

endmodule

`default_nettype wire

/* design/tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module tag_store (
    input  logic                  clk,
    input  logic                  rst,
    // lookup and fill share the index
    input  cache_pkg::line_index_t index,
    input  cache_pkg::line_tag_t   tag,
    output logic                  hit,
    input  logic                  fill,
    // invalidate one line
    input  logic                  flush,
    input  cache_pkg::line_index_t flush_index
);

    import cache_pkg::*;

    logic [`NUM_LINES-1:0] valid;
    line_tag_t             tags [`NUM_LINES];

    assign hit = valid[index] && (tags[index] == tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else begin
            if (fill) begin
                valid[index] <= 1'b1;
            end
            // fill and flush never share a cycle
            if (flush) begin
                valid[flush_index] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tags[index] <= tag;
        end
    end

endmodule

`default_nettype wire

/* design/data_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module data_store (
    input  logic                   clk,
    input  cache_pkg::line_index_t  index,
    input  cache_pkg::word_sel_t    wsel,
    output cache_pkg::word_t        rdata,
    // whole line from dram
    input  logic                   fill,
    input  cache_pkg::line_t        fill_data,
    // byte masked word from core
    input  logic                   write,
    input  cache_pkg::word_byteen_t byteen,
    input  cache_pkg::word_t        wdata
);

    import cache_pkg::*;

    localparam int WORD_BITS = $bits(word_t);

    line_t lines [`NUM_LINES];

    assign rdata = lines[index][wsel*WORD_BITS +: WORD_BITS];

    always_ff @(posedge clk) begin
        if (fill) begin
            lines[index] <= fill_data;
        end else if (write) begin
            for (int b = 0; b < `WORD_BYTES; b++) begin
                if (byteen[b]) begin
                    lines[index][wsel*WORD_BITS + b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/bank_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module bank_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    // core request queue head
    input  logic                   creq_empty,
    input  logic                   creq_rw,
    input  cache_pkg::line_addr_t   creq_addr,
    input  cache_pkg::word_sel_t    creq_wsel,
    input  cache_pkg::word_byteen_t creq_byteen,
    input  cache_pkg::word_t        creq_data,
    input  cache_pkg::core_tag_t    creq_tag,
    output logic                   creq_pop,
    // tag store
    input  logic                   hit,
    output logic                   tag_fill,
    output logic                   tag_flush,
    output cache_pkg::line_index_t  index,
    output cache_pkg::line_tag_t    tag,
    // data store
    input  cache_pkg::word_t        rdata,
    output logic                   data_write,
    output logic                   data_fill,
    output cache_pkg::word_sel_t    wsel,
    // dram request queue
    input  logic                   dreq_full,
    output logic                   dreq_push,
    output logic                   dreq_rw,
    output cache_pkg::line_addr_t   dreq_addr,
    output cache_pkg::line_byteen_t dreq_byteen,
    output cache_pkg::line_t        dreq_data,
    // dram response
    input  logic                   dram_rsp_valid,
    output logic                   dram_rsp_ready,
    // core response
    output logic                   core_rsp_valid,
    output cache_pkg::word_t        core_rsp_data,
    output cache_pkg::core_tag_t    core_rsp_tag,
    input  logic                   core_rsp_ready,
    // flush
    input  logic                   flush_valid,
    output logic                   flush_ready
);

    import cache_pkg::*;

    localparam int INDEX_BITS = $bits(line_index_t);
    localparam int ADDR_BITS  = $bits(line_addr_t);
    localparam int WORD_BITS  = $bits(word_t);
    localparam int BYTE_EN    = $bits(word_byteen_t);

    bank_state_e state;
    logic        idle;
    logic        write_pop;
    logic        read_pop;
    logic        fill_send;
    logic        fill_fire;
    // fill just landed, response word not captured yet
    logic        rsp_load;
    line_addr_t  req_addr;
    word_sel_t   req_wsel;
    line_addr_t  lookup_addr;
    word_t       rsp_data;
    core_tag_t   rsp_tag;

    assign idle = (state == IDLE);

    // flush wins over the core queue
    assign tag_flush   = idle && flush_valid;
    assign flush_ready = idle;

    // writes wait for room in the dram queue
    assign creq_pop  = idle && !flush_valid && !creq_empty && (!creq_rw || !dreq_full);
    assign write_pop = creq_pop && creq_rw;
    assign read_pop  = creq_pop && !creq_rw;

    assign fill_send = (state == FILL_REQ) && !dreq_full;
    assign fill_fire = (state == FILL_WAIT) && dram_rsp_valid;

    assign lookup_addr = idle ? creq_addr : req_addr;
    assign index       = lookup_addr[INDEX_BITS-1:0];
    assign tag         = lookup_addr[ADDR_BITS-1:INDEX_BITS];
    assign wsel        = idle ? creq_wsel : req_wsel;

    assign data_write = write_pop && hit;
    assign data_fill  = fill_fire;
    assign tag_fill   = fill_fire;

    assign dram_rsp_ready = (state == FILL_WAIT);

    // write-through from idle, line fill from FILL_REQ
    assign dreq_push = write_pop || fill_send;
    assign dreq_rw   = idle;
    assign dreq_addr = lookup_addr;

    always_comb begin
        dreq_byteen = '1;
        dreq_data   = '0;
        if (idle) begin
            dreq_byteen = '0;
            dreq_byteen[creq_wsel*BYTE_EN +: BYTE_EN] = creq_byteen;
            dreq_data[creq_wsel*WORD_BITS +: WORD_BITS] = creq_data;
        end
    end

    assign core_rsp_valid = (state == RESPOND) && !rsp_load;
    assign core_rsp_data  = rsp_data;
    assign core_rsp_tag   = rsp_tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            rsp_load <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (read_pop) begin
                        state <= hit ? RESPOND : FILL_REQ;
                    end
                end
                FILL_REQ: begin
                    if (!dreq_full) begin
                        state <= FILL_WAIT;
                    end
                end
                FILL_WAIT: begin
                    if (dram_rsp_valid) begin
                        state    <= RESPOND;
                        rsp_load <= 1'b1;
                    end
                end
                RESPOND: begin
                    if (rsp_load) begin
                        rsp_load <= 1'b0;
                    end else if (core_rsp_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // hit word taken at pop, fill word one cycle after the fill
    always_ff @(posedge clk) begin
        if (read_pop) begin
            req_addr <= creq_addr;
            req_wsel <= creq_wsel;
            rsp_tag  <= creq_tag;
            rsp_data <= rdata;
        end else if ((state == RESPOND) && rsp_load) begin
            rsp_data <= rdata;
        end
    end

endmodule

`default_nettype wire

/* design/cache_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module cache_bank (
    input  logic                   clk,
    input  logic                   rst,
    // core request
    input  logic                   core_req_valid,
    input  logic                   core_req_rw,
    input  cache_pkg::line_addr_t   core_req_addr,
    input  cache_pkg::word_sel_t    core_req_wsel,
    input  cache_pkg::word_byteen_t core_req_byteen,
    input  cache_pkg::word_t        core_req_data,
    input  cache_pkg::core_tag_t    core_req_tag,
    output logic                   core_req_ready,
    // core response
    output logic                   core_rsp_valid,
    output cache_pkg::word_t        core_rsp_data,
    output cache_pkg::core_tag_t    core_rsp_tag,
    input  logic                   core_rsp_ready,
    // dram request
    output logic                   dram_req_valid,
    output logic                   dram_req_rw,
    output cache_pkg::line_addr_t   dram_req_addr,
    output cache_pkg::line_byteen_t dram_req_byteen,
    output cache_pkg::line_t        dram_req_data,
    input  logic                   dram_req_ready,
    // dram response, in order
    input  logic                   dram_rsp_valid,
    input  cache_pkg::line_t        dram_rsp_data,
    output logic                   dram_rsp_ready,
    // flush
    input  logic                   flush_valid,
    input  cache_pkg::line_index_t  flush_index,
    output logic                   flush_ready
);

    import cache_pkg::*;

    localparam int CREQ_WIDTH = 1 + $bits(line_addr_t) + $bits(word_sel_t)
                              + $bits(word_byteen_t) + $bits(word_t) + $bits(core_tag_t);
    localparam int DREQ_WIDTH = 1 + $bits(line_addr_t) + $bits(line_byteen_t) + $bits(line_t);

    logic                  creq_push;
    logic                  creq_pop;
    logic                  creq_full;
    logic                  creq_empty;
    logic [CREQ_WIDTH-1:0] creq_head;
    logic                  creq_rw;
    line_addr_t            creq_addr;
    word_sel_t             creq_wsel;
    word_byteen_t          creq_byteen;
    word_t                 creq_data;
    core_tag_t             creq_tag;

    logic                  dreq_push;
    logic                  dreq_pop;
    logic                  dreq_full;
    logic                  dreq_empty;
    logic [DREQ_WIDTH-1:0] dreq_head;
    logic                  dreq_rw;
    line_addr_t            dreq_addr;
    line_byteen_t          dreq_byteen;
    line_t                 dreq_data;

    line_index_t           index;
    line_tag_t             tag;
    logic                  hit;
    logic                  tag_fill;
    logic                  tag_flush;
    logic                  data_write;
    logic                  data_fill;
    word_sel_t             wsel;
    word_t                 rdata;

    assign core_req_ready = !creq_full;
    assign creq_push      = core_req_valid && core_req_ready;
    assign {creq_rw, creq_addr, creq_wsel, creq_byteen, creq_data, creq_tag} = creq_head;

    req_queue #(
        .DATA_WIDTH (CREQ_WIDTH),
        .DEPTH      (`CREQ_DEPTH)
    ) core_req_queue (
        .clk      (clk),
        .rst      (rst),
        .push     (creq_push),
        .data_in  ({core_req_rw, core_req_addr, core_req_wsel, core_req_byteen,
                    core_req_data, core_req_tag}),
        .pop      (creq_pop),
        .data_out (creq_head),
        .full     (creq_full),
        .empty    (creq_empty)
    );

    tag_store tag_store (
        .clk         (clk),
        .rst         (rst),
        .index       (index),
        .tag         (tag),
        .hit         (hit),
        .fill        (tag_fill),
        .flush       (tag_flush),
        .flush_index (flush_index)
    );

    // write data comes straight from the queue head
    data_store data_store (
        .clk       (clk),
        .index     (index),
        .wsel      (wsel),
        .rdata     (rdata),
        .fill      (data_fill),
        .fill_data (dram_rsp_data),
        .write     (data_write),
        .byteen    (creq_byteen),
        .wdata     (creq_data)
    );

    bank_ctrl bank_ctrl (
        .clk            (clk),
        .rst            (rst),
        .creq_empty     (creq_empty),
        .creq_rw        (creq_rw),
        .creq_addr      (creq_addr),
        .creq_wsel      (creq_wsel),
        .creq_byteen    (creq_byteen),
        .creq_data      (creq_data),
        .creq_tag       (creq_tag),
        .creq_pop       (creq_pop),
        .hit            (hit),
        .tag_fill       (tag_fill),
        .tag_flush      (tag_flush),
        .index          (index),
        .tag            (tag),
        .rdata          (rdata),
        .data_write     (data_write),
        .data_fill      (data_fill),
        .wsel           (wsel),
        .dreq_full      (dreq_full),
        .dreq_push      (dreq_push),
        .dreq_rw        (dreq_rw),
        .dreq_addr      (dreq_addr),
        .dreq_byteen    (dreq_byteen),
        .dreq_data      (dreq_data),
        .dram_rsp_valid (dram_rsp_valid),
        .dram_rsp_ready (dram_rsp_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp_data  (core_rsp_data),
        .core_rsp_tag   (core_rsp_tag),
        .core_rsp_ready (core_rsp_ready),
        .flush_valid    (flush_valid),
        .flush_ready    (flush_ready)
    );

    req_queue #(
        .DATA_WIDTH (DREQ_WIDTH),
        .DEPTH      (`DREQ_DEPTH)
    ) dram_req_queue (
        .clk      (clk),
        .rst      (rst),
        .push     (dreq_push),
        .data_in  ({dreq_rw, dreq_addr, dreq_byteen, dreq_data}),
        .pop      (dreq_pop),
        .data_out (dreq_head),
        .full     (dreq_full),
        .empty    (dreq_empty)
    );

    // queue head drives the dram port
    assign dram_req_valid = !dreq_empty;
    assign dreq_pop       = dram_req_valid && dram_req_ready;
    assign {dram_req_rw, dram_req_addr, dram_req_byteen, dram_req_data} = dreq_head;

endmodule

`default_nettype wire

/* sim/cache_bank_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_bank_assert (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    core_rsp_valid,
    input  logic                    core_rsp_ready,
    input  cache_pkg::word_t        core_rsp_data,
    input  cache_pkg::core_tag_t    core_rsp_tag,
    input  logic                    dram_req_valid,
    input  logic                    dram_req_ready,
    input  logic                    dram_req_rw,
    input  cache_pkg::line_addr_t   dram_req_addr,
    input  cache_pkg::line_byteen_t dram_req_byteen,
    input  cache_pkg::line_t        dram_req_data,
    input  logic                    dram_rsp_ready,
    input  logic                    flush_ready
);

    // outputs quiet from the first cycle of reset on
    reset_quiet: assert property (@(posedge clk)
        rst |=> !core_rsp_valid && !dram_req_valid && !dram_rsp_ready)
        else $error("control outputs active after a reset cycle");

    core_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        core_rsp_valid && !core_rsp_ready |=>
            core_rsp_valid && $stable(core_rsp_data) && $stable(core_rsp_tag))
        else $error("core response changed while stalled");

    dram_req_hold: assert property (@(posedge clk) disable iff (rst)
        dram_req_valid && !dram_req_ready |=>
            dram_req_valid && $stable(dram_req_rw) && $stable(dram_req_addr)
            && $stable(dram_req_byteen) && $stable(dram_req_data))
        else $error("dram request changed while stalled");

    // an unsent fill at the queue head means the controller waits for it
    fill_pending: assert property (@(posedge clk) disable iff (rst)
        dram_req_valid && !dram_req_rw |-> dram_rsp_ready)
        else $error("fill at dram queue head while controller not waiting");

    // flushes are taken only while the controller is idle
    flush_when_idle: assert property (@(posedge clk) disable iff (rst)
        flush_ready |-> !core_rsp_valid && !dram_rsp_ready)
        else $error("flush_ready high while a read is in progress");

endmodule

bind cache_bank cache_bank_assert i_cache_bank_assert (
    .clk             (clk),
    .rst             (rst),
    .core_rsp_valid  (core_rsp_valid),
    .core_rsp_ready  (core_rsp_ready),
    .core_rsp_data   (core_rsp_data),
    .core_rsp_tag    (core_rsp_tag),
    .dram_req_valid  (dram_req_valid),
    .dram_req_ready  (dram_req_ready),
    .dram_req_rw     (dram_req_rw),
    .dram_req_addr   (dram_req_addr),
    .dram_req_byteen (dram_req_byteen),
    .dram_req_data   (dram_req_data),
    .dram_rsp_ready  (dram_rsp_ready),
    .flush_ready     (flush_ready)
);

`default_nettype wire

/* sim/cache_bank_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module cache_bank_tb;

    import cache_pkg::*;

    localparam int          N_REQ          = 400;
    localparam int          TIMEOUT_CYCLES = N_REQ * 40;
    localparam int          POOL_SIZE      = 24;
    localparam int          NUM_ADDR       = 1 << `LINE_ADDR_BITS;
    localparam int          INDEX_BITS     = $bits(line_index_t);
    localparam int          WORD_BITS      = $bits(word_t);
    localparam int          LINE_BYTES     = $bits(line_byteen_t);
    localparam logic [31:0] SEED           = 32'ha4ca84e6;

    typedef struct {
        logic         rw;
        line_addr_t   addr;
        line_byteen_t byteen;
        line_t        data;
    } dram_req_t;

    typedef struct {
        word_t     data;
        core_tag_t tag;
    } core_rsp_t;

    logic         clk;
    logic         rst;
    logic         core_req_valid;
    logic         core_req_rw;
    line_addr_t   core_req_addr;
    word_sel_t    core_req_wsel;
    word_byteen_t core_req_byteen;
    word_t        core_req_data;
    core_tag_t    core_req_tag;
    logic         core_req_ready;
    logic         core_rsp_valid;
    word_t        core_rsp_data;
    core_tag_t    core_rsp_tag;
    logic         core_rsp_ready;
    logic         dram_req_valid;
    logic         dram_req_rw;
    line_addr_t   dram_req_addr;
    line_byteen_t dram_req_byteen;
    line_t        dram_req_data;
    logic         dram_req_ready;
    logic         dram_rsp_valid;
    line_t        dram_rsp_data;
    logic         dram_rsp_ready;
    logic         flush_valid;
    line_index_t  flush_index;
    logic         flush_ready;

    // reference model and dram model
    line_t      ref_mem [NUM_ADDR];
    line_t      dram_mem [NUM_ADDR];
    logic       model_valid [`NUM_LINES];
    line_tag_t  model_tag [`NUM_LINES];
    line_addr_t pool [POOL_SIZE];
    core_rsp_t  exp_rsp_q [$];
    dram_req_t  exp_dreq_q [$];
    line_t      fill_q [$];

    int reset_left;
    int accepted;
    int cycles;
    int rsp_span;
    int dreq_span;
    int fill_delay;
    bit req_sent;
    bit flush_sent;
    bit fill_sent;
    bit saw_req_full;

    cache_bank i_cache_bank (
        .clk             (clk),
        .rst             (rst),
        .core_req_valid  (core_req_valid),
        .core_req_rw     (core_req_rw),
        .core_req_addr   (core_req_addr),
        .core_req_wsel   (core_req_wsel),
        .core_req_byteen (core_req_byteen),
        .core_req_data   (core_req_data),
        .core_req_tag    (core_req_tag),
        .core_req_ready  (core_req_ready),
        .core_rsp_valid  (core_rsp_valid),
        .core_rsp_data   (core_rsp_data),
        .core_rsp_tag    (core_rsp_tag),
        .core_rsp_ready  (core_rsp_ready),
        .dram_req_valid  (dram_req_valid),
        .dram_req_rw     (dram_req_rw),
        .dram_req_addr   (dram_req_addr),
        .dram_req_byteen (dram_req_byteen),
        .dram_req_data   (dram_req_data),
        .dram_req_ready  (dram_req_ready),
        .dram_rsp_valid  (dram_rsp_valid),
        .dram_rsp_data   (dram_rsp_data),
        .dram_rsp_ready  (dram_rsp_ready),
        .flush_valid     (flush_valid),
        .flush_index     (flush_index),
        .flush_ready     (flush_ready)
    );

    always #10 clk = ~clk;

    // every word differs, built from line address and word position
    function automatic line_t init_line(input line_addr_t addr);
        line_t line;
        for (int w = 0; w < `LINE_WORDS; w++) begin
            line[w*WORD_BITS +: WORD_BITS] =
                (word_t'({addr, word_sel_t'(w)}) * 32'h9e3779b1) ^ 32'h0f0f0000;
        end
        return line;
    endfunction

    function automatic line_t byte_mask(input line_byteen_t be);
        line_t mask;
        for (int b = 0; b < LINE_BYTES; b++) begin
            mask[b*8 +: 8] = {8{be[b]}};
        end
        return mask;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at time %0t", $time);
    endtask

    task automatic report_mismatch(input string msg);
        stop_with_failure($sformatf("CHECK FAILED at time %0t: %s", $time, msg));
    endtask

    task automatic compare_core_rsp(input word_t got_data, input core_tag_t got_tag,
                                    input word_t want_data, input core_tag_t want_tag);
        if (got_tag !== want_tag || got_data !== want_data) begin
            report_mismatch($sformatf("core response tag %h data %h, expected tag %h data %h",
                                      got_tag, got_data, want_tag, want_data));
        end
    endtask

    task automatic compare_dram_req(input logic got_rw, input line_addr_t got_addr,
                                    input line_byteen_t got_be, input line_t got_data,
                                    input dram_req_t want);
        line_t mask;
        // fills carry no data
        mask = want.rw ? byte_mask(want.byteen) : '0;
        if (got_rw !== want.rw || got_addr !== want.addr || got_be !== want.byteen
            || (got_data & mask) !== (want.data & mask)) begin
            report_mismatch($sformatf({"dram request rw %b addr %h byteen %h data %h, ",
                                       "expected rw %b addr %h byteen %h data %h"},
                got_rw, got_addr, got_be, got_data & mask,
                want.rw, want.addr, want.byteen, want.data & mask));
        end
    endtask

    task automatic accept_core_req();
        line_index_t idx;
        line_tag_t   tg;
        int          sel;
        dram_req_t   req;
        core_rsp_t   rsp;
        idx = core_req_addr[INDEX_BITS-1:0];
        tg  = core_req_addr[`LINE_ADDR_BITS-1:INDEX_BITS];
        sel = int'(core_req_wsel);
        accepted++;
        if (core_req_rw) begin
            req.rw     = 1'b1;
            req.addr   = core_req_addr;
            req.byteen = line_byteen_t'(core_req_byteen) << (sel * `WORD_BYTES);
            req.data   = line_t'(core_req_data) << (sel * WORD_BITS);
            exp_dreq_q.push_back(req);
            for (int b = 0; b < `WORD_BYTES; b++) begin
                if (core_req_byteen[b]) begin
                    ref_mem[core_req_addr][sel*WORD_BITS + b*8 +: 8] = core_req_data[b*8 +: 8];
                end
            end
        end else begin
            // miss in the model means one fill, then the line is resident
            if (!(model_valid[idx] && model_tag[idx] == tg)) begin
                req.rw     = 1'b0;
                req.addr   = core_req_addr;
                req.byteen = '1;
                req.data   = '0;
                exp_dreq_q.push_back(req);
                model_valid[idx] = 1'b1;
                model_tag[idx]   = tg;
            end
            rsp.tag  = core_req_tag;
            rsp.data = ref_mem[core_req_addr][sel*WORD_BITS +: WORD_BITS];
            exp_rsp_q.push_back(rsp);
        end
    endtask

    task automatic check_core_rsp();
        core_rsp_t want;
        if (exp_rsp_q.size() == 0) begin
            stop_with_failure("core response arrived with no read outstanding");
        end else begin
            want = exp_rsp_q.pop_front();
            compare_core_rsp(core_rsp_data, core_rsp_tag, want.data, want.tag);
        end
    endtask

    task automatic accept_dram_req();
        dram_req_t want;
        if (exp_dreq_q.size() == 0) begin
            stop_with_failure("dram request arrived when none was expected");
        end else begin
            want = exp_dreq_q.pop_front();
            compare_dram_req(dram_req_rw, dram_req_addr, dram_req_byteen, dram_req_data, want);
            if (dram_req_rw) begin
                for (int b = 0; b < LINE_BYTES; b++) begin
                    if (dram_req_byteen[b]) begin
                        dram_mem[dram_req_addr][b*8 +: 8] = dram_req_data[b*8 +: 8];
                    end
                end
            end else begin
                fill_q.push_back(dram_mem[dram_req_addr]);
            end
        end
    endtask

    task automatic drive_core_req();
        if (!core_req_valid || req_sent) begin
            req_sent       = 1'b0;
            core_req_valid = 1'b0;
            if (accepted < N_REQ && $urandom_range(0, 9) < 7) begin
                core_req_valid  = 1'b1;
                core_req_rw     = ($urandom_range(0, 9) < 4);
                core_req_addr   = pool[$urandom_range(0, POOL_SIZE - 1)];
                core_req_wsel   = word_sel_t'($urandom);
                core_req_byteen = word_byteen_t'($urandom);
                core_req_data   = word_t'($urandom);
                core_req_tag    = core_tag_t'($urandom);
            end
        end
    endtask

    // flushes only while no read is outstanding, so model order matches
    task automatic drive_flush();
        if (flush_valid && flush_sent) begin
            flush_valid = 1'b0;
            flush_sent  = 1'b0;
        end
        if (!flush_valid && accepted < N_REQ && exp_rsp_q.size() == 0
            && $urandom_range(0, 15) == 0) begin
            flush_valid = 1'b1;
            flush_index = line_index_t'($urandom);
        end
    endtask

    task automatic pick_ready(inout int span, inout logic ready);
        if (span == 0) begin
            span  = $urandom_range(1, 20);
            ready = ($urandom_range(0, 3) != 0);
        end
        span--;
    endtask

    task automatic drive_dram_rsp();
        if (dram_rsp_valid && fill_sent) begin
            dram_rsp_valid = 1'b0;
            fill_sent      = 1'b0;
        end
        if (!dram_rsp_valid && fill_q.size() > 0) begin
            if (fill_delay == 0) begin
                dram_rsp_valid = 1'b1;
                dram_rsp_data  = fill_q[0];
                fill_delay     = $urandom_range(0, 6);
            end else begin
                fill_delay--;
            end
        end
    endtask

    // stimulus, 1 ns after the rising edge
    always @(posedge clk) begin
        #1;
        if (reset_left > 0) begin
            reset_left--;
            rst = (reset_left > 0);
        end else begin
            drive_core_req();
            drive_flush();
            pick_ready(rsp_span, core_rsp_ready);
            pick_ready(dreq_span, dram_req_ready);
            drive_dram_rsp();
        end
    end

    // handshakes sampled mid-cycle, when all inputs are settled
    always @(negedge clk) begin
        if (!rst) begin
            if (!core_req_ready) begin
                saw_req_full = 1'b1;
            end
            if (flush_valid && flush_ready) begin
                model_valid[flush_index] = 1'b0;
                flush_sent = 1'b1;
            end
            if (core_req_valid && core_req_ready) begin
                accept_core_req();
                req_sent = 1'b1;
            end
            if (core_rsp_valid && core_rsp_ready) begin
                check_core_rsp();
            end
            if (dram_req_valid && dram_req_ready) begin
                accept_dram_req();
            end
            if (dram_rsp_valid && dram_rsp_ready) begin
                void'(fill_q.pop_front());
                fill_sent = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("timeout after %0d cycles, %0d of %0d requests accepted",
                                        cycles, accepted, N_REQ));
        end
    end

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        core_req_valid  = 1'b0;
        core_req_rw     = 1'b0;
        core_req_addr   = '0;
        core_req_wsel   = '0;
        core_req_byteen = '0;
        core_req_data   = '0;
        core_req_tag    = '0;
        core_rsp_ready  = 1'b0;
        dram_req_ready  = 1'b0;
        dram_rsp_valid  = 1'b0;
        dram_rsp_data   = '0;
        flush_valid     = 1'b0;
        flush_index     = '0;
        reset_left      = 2;
        void'($urandom(SEED));
        for (int a = 0; a < NUM_ADDR; a++) begin
            ref_mem[a]  = init_line(line_addr_t'(a));
            dram_mem[a] = init_line(line_addr_t'(a));
        end
        for (int i = 0; i < `NUM_LINES; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end
        // 24 lines over 16 indices forces conflicts
        for (int i = 0; i < POOL_SIZE; i++) begin
            pool[i] = line_addr_t'($urandom);
        end
        wait (!rst);
        while (accepted < N_REQ || exp_rsp_q.size() != 0 || exp_dreq_q.size() != 0
               || fill_q.size() != 0) begin
            @(posedge clk);
        end
        // stray responses or requests would show up here
        repeat (20) @(posedge clk);
        if (!saw_req_full) begin
            stop_with_failure("core_req_ready never fell, the core queue never filled");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+design
design/cache_pkg.sv
design/req_queue.sv
design/tag_store.sv
design/data_store.sv
design/bank_ctrl.sv
design/cache_bank.sv
sim/cache_bank_assert.sv
sim/cache_bank_tb.sv

/* Makefile */
TOP = cache_bank_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
